//--- rtl/cw_trig_io_pkg.sv
`default_nettype none

package cw_trig_io_pkg;

	typedef logic [5:0] reg_addr_t; // host register address

	localparam reg_addr_t TRIGSRC_ADDR = 6'd39; // external trigger combine, 1 byte
	localparam reg_addr_t TRIGMOD_ADDR = 6'd40; // trigger module select, 1 byte
	localparam reg_addr_t IOROUTE_ADDR = 6'd55; // target io routing, 8 bytes
	localparam reg_addr_t IOREAD_ADDR  = 6'd59; // sampled pin levels, read only

	typedef enum logic [1:0] {
		TRIG_COMB_OR   = 2'd0, // any enabled line
		TRIG_COMB_AND  = 2'd1, // all enabled lines
		TRIG_COMB_NAND = 2'd2, // inverted and
		TRIG_COMB_OFF  = 2'd3  // forces 0
	} trig_comb_t;

	typedef enum logic [2:0] {
		TRIG_SEL_EXT        = 3'd0, // combined external edge
		TRIG_SEL_ADVIO      = 3'd1, // advanced io pattern
		TRIG_SEL_ANAPATTERN = 3'd2, // analog pattern match
		TRIG_SEL_DECODEDIO  = 3'd3  // decoded io; codes 4..7 give 0
	} trig_sel_t;

	typedef struct packed {
		trig_comb_t  comb; // bits 7:6
		logic [5:0]  en;   // io4 io3 io2 io1 nrst fpa
	} trig_src_t;

	typedef struct packed {
		logic [3:0] unused;
		logic       fpa_out; // drive trigger onto front panel A
		trig_sel_t  sel;
	} trig_mod_t;

	typedef struct packed {
		logic gpio_en;
		logic gpio_val;
		logic uart_oc;     // pin 3 only
		logic usi_oc;      // pin 3 only
		logic usi_in_sel;
		logic usi_out_sel;
		logic rx_sel;
		logic tx_sel;
	} pin_route_t;

	typedef struct packed {
		logic [5:0] unused;
		logic       power_off;  // 1 cuts target power
		logic       avrprog_en;
	} extra_ctrl_t;

	typedef struct packed {
		logic unused;
		logic nrst_ignore_highz;
		logic pdic_val;
		logic pdic_en;
		logic pdid_val;
		logic pdid_en;
		logic nrst_val;
		logic nrst_en;
	} gpio_ctrl_t;

	typedef struct packed {
		logic [7:0]       reserved; // byte 7
		gpio_ctrl_t       gpio;     // byte 6
		extra_ctrl_t      extra;    // byte 5
		logic [7:0]       glitch;   // byte 4, stored only
		pin_route_t [3:0] pin;      // bytes 3..0, pin 1 is index 0
	} io_route_t;

	typedef struct packed {
		trig_src_t trig_src;
		trig_mod_t trig_mod;
		io_route_t io_route;
	} ctrl_regs_t;

	typedef struct packed {
		logic io4;
		logic io3;
		logic io2;
		logic io1;
		logic nrst;
		logic fpa; // bit 0, same order as trig_src_t.en
	} trig_lines_t;

	typedef struct packed {
		logic advio;
		logic anapattern;
		logic decodedio;
	} adv_trig_t;

	typedef struct packed {
		logic value;
		logic oe; // 0 means released
	} pin_drive_t;

	typedef struct packed {
		pin_drive_t [3:0] pin; // pin 1 is index 0
	} pin_drives_t;

	localparam trig_src_t TRIGSRC_RESET = '{comb: TRIG_COMB_OR, en: 6'b00_0001}; // fpa only
	localparam io_route_t IOROUTE_RESET = 64'h0000_0000_0000_0201; // pin1 tx, pin2 rx

endpackage

`default_nettype wire

//--- rtl/cw_reg_bank.sv
`timescale 1ns/10ps
`default_nettype none

module cw_reg_bank (
	input  wire logic                      clk,
	input  wire logic                      reset,
	input  wire logic                      reg_write_i,   // write strobe
	input  wire cw_trig_io_pkg::reg_addr_t reg_address_i,
	input  wire logic [15:0]               reg_bytecnt_i, // byte lane within register
	input  wire logic [7:0]                reg_datai_i,
	output      cw_trig_io_pkg::ctrl_regs_t regs_o
);

	cw_trig_io_pkg::ctrl_regs_t regs_q; // control register state
	logic [5:0] lane_lsb;               // bit offset of selected ioroute byte

	assign lane_lsb = {reg_bytecnt_i[2:0], 3'b000}; // byte count modulo 8

	always_ff @(posedge clk) begin
		if (reset) begin
			regs_q.trig_src <= cw_trig_io_pkg::TRIGSRC_RESET;
			regs_q.trig_mod <= '0;                          // edge module, fpa not driven
			regs_q.io_route <= cw_trig_io_pkg::IOROUTE_RESET;
		end else if (reg_write_i) begin
			case (reg_address_i)
				cw_trig_io_pkg::TRIGSRC_ADDR: begin
					regs_q.trig_src <= reg_datai_i;
				end
				cw_trig_io_pkg::TRIGMOD_ADDR: begin
					regs_q.trig_mod <= reg_datai_i;
				end
				cw_trig_io_pkg::IOROUTE_ADDR: begin
					regs_q.io_route[lane_lsb +: 8] <= reg_datai_i; // one byte per beat
				end
				default: begin
					// ioread and unknown addresses ignore writes
				end
			endcase
		end
	end

	assign regs_o = regs_q; // visible the cycle after the write edge

	// the host walks ioroute bytes 0..7, anything higher would alias a lower lane
	a_ioroute_lane: assert property (
		@(posedge clk) disable iff (reset)
		(reg_write_i && reg_address_i == cw_trig_io_pkg::IOROUTE_ADDR) |-> (reg_bytecnt_i < 16'd8)
	) else $error("ioroute write with byte count %0d", reg_bytecnt_i);

endmodule

`default_nettype wire

//--- rtl/cw_trigger_mux.sv
`timescale 1ns/10ps
`default_nettype none

module cw_trigger_mux (
	input  wire cw_trig_io_pkg::trig_src_t   trig_src_i,
	input  wire cw_trig_io_pkg::trig_mod_t   trig_mod_i,
	input  wire cw_trig_io_pkg::trig_lines_t lines_i,  // external trigger inputs
	input  wire cw_trig_io_pkg::adv_trig_t   adv_i,    // advanced trigger modules
	output      logic                        trigger_ext_o,
	output      logic                        trigger_o,
	output      cw_trig_io_pkg::pin_drive_t  fpa_drive_o
);

	logic [5:0] lines;    // flat view of the inputs
	logic       trig_or;  // disabled lines count as 0
	logic       trig_and; // disabled lines count as 1
	logic       trig_ext;
	logic       trig;

	assign lines    = lines_i;
	assign trig_or  = |(lines & trig_src_i.en);
	assign trig_and = &(lines | ~trig_src_i.en);

	always_comb begin
		case (trig_src_i.comb)
			cw_trig_io_pkg::TRIG_COMB_OR:   trig_ext = trig_or;
			cw_trig_io_pkg::TRIG_COMB_AND:  trig_ext = trig_and;
			cw_trig_io_pkg::TRIG_COMB_NAND: trig_ext = ~trig_and;
			default:                        trig_ext = 1'b0; // off
		endcase
	end

	always_comb begin
		case (trig_mod_i.sel)
			cw_trig_io_pkg::TRIG_SEL_EXT:        trig = trig_ext;
			cw_trig_io_pkg::TRIG_SEL_ADVIO:      trig = adv_i.advio;
			cw_trig_io_pkg::TRIG_SEL_ANAPATTERN: trig = adv_i.anapattern;
			cw_trig_io_pkg::TRIG_SEL_DECODEDIO:  trig = adv_i.decodedio;
			default:                             trig = 1'b0; // codes 4..7
		endcase
	end

	assign trigger_ext_o     = trig_ext;
	assign trigger_o         = trig;       // same cycle as the inputs
	assign fpa_drive_o.value = trig;       // mirror capture trigger on fpa
	assign fpa_drive_o.oe    = trig_mod_i.fpa_out;

	// no capture trigger may come from an unassigned module code
	a_sel_range: assert final (trig_mod_i.sel < 3'd4 || !trigger_o)
		else $error("trigger with module code %0d", trig_mod_i.sel);

endmodule

`default_nettype wire

//--- rtl/cw_target_io_router.sv
`timescale 1ns/10ps
`default_nettype none

module cw_target_io_router (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire cw_trig_io_pkg::io_route_t   route_i,
	input  wire logic [3:0]                  pins_i,    // levels seen on target io 4..1
	input  wire logic                        uart_tx_i,
	input  wire logic                        usi_out_i,
	output      cw_trig_io_pkg::pin_drives_t pins_o,
	output      logic                        uart_rx_o,
	output      logic                        usi_in_o,
	output      logic                        targetpower_off_o,
	output      logic                        avrprog_en_o,
	output      cw_trig_io_pkg::gpio_ctrl_t  gpio_o
);

	logic                        power_off_q; // pins blank one cycle after the register
	cw_trig_io_pkg::pin_drives_t drv;
	logic [3:0]                  oe_vec;      // per pin output enable, for checking
	logic                        uart_rx;
	logic                        usi_in;

	always_ff @(posedge clk) begin
		if (reset) begin
			power_off_q <= 1'b0;
		end else begin
			power_off_q <= route_i.extra.power_off;
		end
	end

	// first match wins, pin 3 is index 2, pin 4 has tx and gpio only
	always_comb begin
		drv = '0; // released
		for (int i = 0; i < 4; i++) begin
			if (power_off_q) begin
				drv.pin[i] = '0; // target unpowered, never back-drive
			end else if (route_i.pin[i].tx_sel) begin
				drv.pin[i] = '{value: uart_tx_i, oe: 1'b1};
			end else if (route_i.pin[i].usi_out_sel && i < 3) begin
				drv.pin[i] = '{value: usi_out_i, oe: 1'b1};
			end else if (route_i.pin[i].usi_oc && i == 2) begin
				drv.pin[i] = '{value: 1'b0, oe: ~usi_out_i}; // pull low only
			end else if (route_i.pin[i].uart_oc && i == 2) begin
				drv.pin[i] = '{value: 1'b0, oe: ~uart_tx_i};
			end else if (route_i.pin[i].gpio_en) begin
				drv.pin[i] = '{value: route_i.pin[i].gpio_val, oe: 1'b1};
			end
		end
	end

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			oe_vec[i] = drv.pin[i].oe;
		end
	end

	// lowest numbered pin wins, so scan from the top down
	always_comb begin
		uart_rx = 1'b1; // idle level when nothing is routed
		for (int i = 3; i >= 0; i--) begin
			if (route_i.pin[i].rx_sel) begin
				uart_rx = pins_i[i];
			end
		end
	end

	always_comb begin
		usi_in = 1'b1; // pins 1..3 only
		for (int i = 2; i >= 0; i--) begin
			if (route_i.pin[i].usi_in_sel) begin
				usi_in = pins_i[i];
			end
		end
	end

	assign pins_o            = drv;
	assign uart_rx_o         = uart_rx;
	assign usi_in_o          = usi_in;
	assign targetpower_off_o = power_off_q;
	assign avrprog_en_o      = route_i.extra.avrprog_en;
	assign gpio_o            = route_i.gpio; // nrst, pdid, pdic go straight out

	// once power_off has been in the register for a cycle every pin is released
	a_blank_when_off: assert property (
		@(posedge clk) disable iff (reset)
		route_i.extra.power_off |=> (oe_vec == 4'b0000)
	) else $error("pin driven while target power off, oe %b", oe_vec);

endmodule

`default_nettype wire

//--- rtl/cw_reg_readback.sv
`timescale 1ns/10ps
`default_nettype none

module cw_reg_readback (
	input  wire logic                       clk,
	input  wire logic                       reset,
	input  wire logic                       reg_read_i,
	input  wire logic                       reg_addrvalid_i,
	input  wire cw_trig_io_pkg::reg_addr_t  reg_address_i,
	input  wire cw_trig_io_pkg::reg_addr_t  reg_hypaddress_i, // length lookup address
	input  wire logic [15:0]                reg_bytecnt_i,
	input  wire cw_trig_io_pkg::ctrl_regs_t regs_i,
	input  wire logic [3:0]                 pins_i,
	output      logic [7:0]                 reg_datao_o,
	output      logic [15:0]                reg_hyplen_o
);

	logic [3:0] ioread_q; // pin levels from the previous edge
	logic [7:0] data_q;
	logic       valid_q;  // address known, gates the read data
	logic [5:0] lane_lsb;

	// register length in bytes, 0 marks an unknown address
	function automatic logic [15:0] reg_len(input cw_trig_io_pkg::reg_addr_t addr);
		case (addr)
			cw_trig_io_pkg::TRIGSRC_ADDR: reg_len = 16'd1;
			cw_trig_io_pkg::TRIGMOD_ADDR: reg_len = 16'd1;
			cw_trig_io_pkg::IOROUTE_ADDR: reg_len = 16'd8;
			cw_trig_io_pkg::IOREAD_ADDR:  reg_len = 16'd1;
			default:                      reg_len = 16'd0;
		endcase
	endfunction

	assign lane_lsb = {reg_bytecnt_i[2:0], 3'b000};

	always_ff @(posedge clk) begin
		if (reset) begin
			ioread_q <= 4'b0000;
			valid_q  <= 1'b0;
		end else begin
			ioread_q <= pins_i; // sampled every clock
			valid_q  <= reg_addrvalid_i && (reg_len(reg_address_i) != 16'd0);
		end
	end

	always_ff @(posedge clk) begin
		if (reg_read_i) begin
			case (reg_address_i)
				cw_trig_io_pkg::TRIGSRC_ADDR: data_q <= regs_i.trig_src;
				cw_trig_io_pkg::TRIGMOD_ADDR: data_q <= regs_i.trig_mod;
				cw_trig_io_pkg::IOROUTE_ADDR: data_q <= regs_i.io_route[lane_lsb +: 8];
				cw_trig_io_pkg::IOREAD_ADDR:  data_q <= {4'b0000, ioread_q};
				default:                      data_q <= 8'h00;
			endcase
		end
	end

	assign reg_datao_o  = valid_q ? data_q : 8'h00; // reads 0 outside a valid access
	assign reg_hyplen_o = reg_len(reg_hypaddress_i);   // combinational for the host

endmodule

`default_nettype wire

//--- rtl/cw_trig_io_top.sv
`timescale 1ns/10ps
`default_nettype none

module cw_trig_io_top (
	input  wire logic                        clk,
	input  wire logic                        reset,
	input  wire logic                        reg_write_i,
	input  wire logic                        reg_read_i,
	input  wire logic                        reg_addrvalid_i,
	input  wire cw_trig_io_pkg::reg_addr_t   reg_address_i,
	input  wire cw_trig_io_pkg::reg_addr_t   reg_hypaddress_i,
	input  wire logic [15:0]                 reg_bytecnt_i,
	input  wire logic [7:0]                  reg_datai_i,
	input  wire cw_trig_io_pkg::trig_lines_t lines_i,
	input  wire cw_trig_io_pkg::adv_trig_t   adv_i,
	input  wire logic [3:0]                  pins_i,
	input  wire logic                        uart_tx_i,
	input  wire logic                        usi_out_i,
	output      logic [7:0]                  reg_datao_o,
	output      logic [15:0]                 reg_hyplen_o,
	output      logic                        trigger_ext_o,
	output      logic                        trigger_o,      // to the capture system
	output      cw_trig_io_pkg::pin_drive_t  fpa_drive_o,
	output      cw_trig_io_pkg::pin_drives_t pins_o,
	output      logic                        uart_rx_o,
	output      logic                        usi_in_o,
	output      logic                        targetpower_off_o,
	output      logic                        avrprog_en_o,
	output      cw_trig_io_pkg::gpio_ctrl_t  gpio_o
);

	cw_trig_io_pkg::ctrl_regs_t regs; // shared control state

	cw_reg_bank i_reg_bank (
		.clk           (clk),
		.reset         (reset),
		.reg_write_i   (reg_write_i),
		.reg_address_i (reg_address_i),
		.reg_bytecnt_i (reg_bytecnt_i),
		.reg_datai_i   (reg_datai_i),
		.regs_o        (regs)
	);

	cw_trigger_mux i_trigger_mux (
		.trig_src_i    (regs.trig_src),
		.trig_mod_i    (regs.trig_mod),
		.lines_i       (lines_i),
		.adv_i         (adv_i),
		.trigger_ext_o (trigger_ext_o),
		.trigger_o     (trigger_o),
		.fpa_drive_o   (fpa_drive_o)
	);

	cw_target_io_router i_io_router (
		.clk               (clk),
		.reset             (reset),
		.route_i           (regs.io_route),
		.pins_i            (pins_i),
		.uart_tx_i         (uart_tx_i),
		.usi_out_i         (usi_out_i),
		.pins_o            (pins_o),
		.uart_rx_o         (uart_rx_o),
		.usi_in_o          (usi_in_o),
		.targetpower_off_o (targetpower_off_o),
		.avrprog_en_o      (avrprog_en_o),
		.gpio_o            (gpio_o)
	);

	cw_reg_readback i_readback (
		.clk              (clk),
		.reset            (reset),
		.reg_read_i       (reg_read_i),
		.reg_addrvalid_i  (reg_addrvalid_i),
		.reg_address_i    (reg_address_i),
		.reg_hypaddress_i (reg_hypaddress_i),
		.reg_bytecnt_i    (reg_bytecnt_i),
		.regs_i           (regs),
		.pins_i           (pins_i),
		.reg_datao_o      (reg_datao_o),
		.reg_hyplen_o     (reg_hyplen_o)
	);

endmodule

`default_nettype wire

//--- tb/cw_trig_io_tb.sv
`timescale 1ns/10ps
`default_nettype none

module cw_trig_io_tb;

	localparam int CLK_PERIOD  = 4;
	localparam int N_ROUNDS    = 4;   // write/readback passes over all ten byte targets
	localparam int N_TRIG      = 200;
	localparam int N_PIN       = 200;
	localparam int N_OFF       = 20;
	localparam int TEST_CYCLES = 64 + 20 * N_ROUNDS + 2 * N_TRIG + N_PIN + 2 * N_OFF + 20;

	logic        clk;
	logic        reset;
	logic        reg_write_i;
	logic        reg_read_i;
	logic        reg_addrvalid_i;
	logic [5:0]  reg_address_i;
	logic [5:0]  reg_hypaddress_i;
	logic [15:0] reg_bytecnt_i;
	logic [7:0]  reg_datai_i;
	logic [5:0]  lines_i;
	logic [2:0]  adv_i;           // advio anapattern decodedio
	logic [3:0]  pins_i;
	logic        uart_tx_i;
	logic        usi_out_i;
	logic [7:0]  reg_datao_o;
	logic [15:0] reg_hyplen_o;
	logic        trigger_ext_o;
	logic        trigger_o;
	logic [1:0]  fpa_drive_o;     // value oe
	logic [7:0]  pins_o;          // {value, oe} per pin, pin 1 lowest
	logic        uart_rx_o;
	logic        usi_in_o;
	logic        targetpower_off_o;
	logic        avrprog_en_o;
	logic [7:0]  gpio_o;

	logic [31:0] seed = 32'h1568a777;
	int          errors = 0;
	int          checks = 0;

	logic [7:0]  sh_src;          // shadow of the control registers
	logic [7:0]  sh_mod;
	logic [63:0] sh_route;
	logic        exp_power_off;   // one edge behind the routing byte
	logic [3:0]  exp_ioread;
	logic [7:0]  exp_data;
	logic        exp_valid;

	cw_trig_io_top i_dut (
		.clk               (clk),
		.reset             (reset),
		.reg_write_i       (reg_write_i),
		.reg_read_i        (reg_read_i),
		.reg_addrvalid_i   (reg_addrvalid_i),
		.reg_address_i     (reg_address_i),
		.reg_hypaddress_i  (reg_hypaddress_i),
		.reg_bytecnt_i     (reg_bytecnt_i),
		.reg_datai_i       (reg_datai_i),
		.lines_i           (lines_i),
		.adv_i             (adv_i),
		.pins_i            (pins_i),
		.uart_tx_i         (uart_tx_i),
		.usi_out_i         (usi_out_i),
		.reg_datao_o       (reg_datao_o),
		.reg_hyplen_o      (reg_hyplen_o),
		.trigger_ext_o     (trigger_ext_o),
		.trigger_o         (trigger_o),
		.fpa_drive_o       (fpa_drive_o),
		.pins_o            (pins_o),
		.uart_rx_o         (uart_rx_o),
		.usi_in_o          (usi_in_o),
		.targetpower_off_o (targetpower_off_o),
		.avrprog_en_o      (avrprog_en_o),
		.gpio_o            (gpio_o)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		seed = seed * 32'd1664525 + 32'd1013904223; // use the upper bits, low ones are weak
		return seed;
	endfunction

	function automatic logic [15:0] ref_len(input logic [5:0] addr);
		case (addr)
			cw_trig_io_pkg::TRIGSRC_ADDR: return 16'd1;
			cw_trig_io_pkg::TRIGMOD_ADDR: return 16'd1;
			cw_trig_io_pkg::IOROUTE_ADDR: return 16'd8;
			cw_trig_io_pkg::IOREAD_ADDR:  return 16'd1;
			default:                      return 16'd0;
		endcase
	endfunction

	// returns {trigger_ext, trigger}
	function automatic logic [1:0] ref_trigger(input logic [7:0] src, input logic [7:0] mod,
			input logic [5:0] lines, input logic [2:0] adv);
		logic any_hit;
		logic all_hit;
		logic ext;
		logic trig;
		any_hit = 1'b0;
		all_hit = 1'b1; // nothing enabled gives and = 1
		for (int i = 0; i < 6; i++) begin
			if (src[i]) begin
				any_hit = any_hit | lines[i];
				all_hit = all_hit & lines[i];
			end
		end
		case (src[7:6])
			2'd0:    ext = any_hit;
			2'd1:    ext = all_hit;
			2'd2:    ext = ~all_hit;
			default: ext = 1'b0;
		endcase
		case (mod[2:0])
			3'd0:    trig = ext;
			3'd1:    trig = adv[2];
			3'd2:    trig = adv[1];
			3'd3:    trig = adv[0];
			default: trig = 1'b0;
		endcase
		return {ext, trig};
	endfunction

	// per pin {value, oe}, first matching rule wins
	function automatic logic [7:0] ref_drives(input logic [31:0] route, input logic off,
			input logic tx, input logic usi);
		logic [7:0] b;
		logic [1:0] d;
		logic [7:0] res;
		for (int i = 0; i < 4; i++) begin
			b = route[8 * i +: 8];
			if (off)                 d = 2'b00;
			else if (b[0])           d = {tx, 1'b1};        // tx_sel
			else if (b[2] && i < 3)  d = {usi, 1'b1};       // usi_out_sel, not on pin 4
			else if (b[4] && i == 2) d = {1'b0, ~usi};      // usi open collector
			else if (b[5] && i == 2) d = {1'b0, ~tx};       // uart open collector
			else if (b[7])           d = {b[6], 1'b1};      // gpio
			else                     d = 2'b00;
			res[2 * i +: 2] = d;
		end
		return res;
	endfunction

	// returns {uart_rx, usi_in}, lowest selected pin wins
	function automatic logic [1:0] ref_receive(input logic [31:0] route, input logic [3:0] pins);
		logic uart;
		logic usi;
		logic uart_hit;
		logic usi_hit;
		uart = 1'b1;
		usi = 1'b1;
		uart_hit = 1'b0;
		usi_hit = 1'b0;
		for (int i = 0; i < 4; i++) begin
			if (!uart_hit && route[8 * i + 1]) begin
				uart = pins[i];
				uart_hit = 1'b1;
			end
			if (i < 3 && !usi_hit && route[8 * i + 3]) begin
				usi = pins[i];
				usi_hit = 1'b1;
			end
		end
		return {uart, usi};
	endfunction

	task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] got);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("CHECK FAILED at %0t: %s expected %0h got %0h", $time, name, exp, got);
		end
	endtask

	// random target side levels; driven pins follow the drive, floating ones are random
	task automatic drive_io();
		logic [31:0] r;
		logic [7:0]  drv;
		r = next_rand();
		lines_i = r[21:16];
		adv_i = r[24:22];
		uart_tx_i = r[25];
		usi_out_i = r[26];
		drv = ref_drives(sh_route[31:0], exp_power_off, uart_tx_i, usi_out_i);
		for (int i = 0; i < 4; i++) begin
			pins_i[i] = drv[2 * i] ? drv[2 * i + 1] : r[27 + i];
		end
	endtask

	task automatic next_cycle();
		@(posedge clk);
		#1;
		reg_write_i = 1'b0;
		reg_read_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		drive_io();
	endtask

	task automatic host_write(input logic [5:0] addr, input logic [2:0] lane, input logic [7:0] data);
		next_cycle();
		reg_write_i = 1'b1;
		reg_address_i = addr;
		reg_bytecnt_i = {13'd0, lane};
		reg_datai_i = data;
	endtask

	task automatic host_read(input logic [5:0] addr, input logic [2:0] lane);
		next_cycle();
		reg_read_i = 1'b1;
		reg_addrvalid_i = 1'b1;
		reg_address_i = addr;
		reg_bytecnt_i = {13'd0, lane};
	endtask

	// shadow registers follow the host strobes at the same edge as the DUT
	always @(posedge clk) begin
		if (reset) begin
			sh_src <= 8'h01;                    // fpa enabled, or mode
			sh_mod <= 8'h00;
			sh_route <= 64'h0000_0000_0000_0201; // pin 1 tx, pin 2 rx
			exp_power_off <= 1'b0;
			exp_ioread <= 4'h0;
			exp_data <= 8'h00;
			exp_valid <= 1'b0;
		end else begin
			exp_power_off <= sh_route[41];
			exp_ioread <= pins_i;
			exp_valid <= reg_addrvalid_i && (ref_len(reg_address_i) != 16'd0);
			if (reg_read_i) begin
				case (reg_address_i)
					cw_trig_io_pkg::TRIGSRC_ADDR: exp_data <= sh_src;
					cw_trig_io_pkg::TRIGMOD_ADDR: exp_data <= sh_mod;
					cw_trig_io_pkg::IOROUTE_ADDR: exp_data <= sh_route[8 * reg_bytecnt_i[2:0] +: 8];
					cw_trig_io_pkg::IOREAD_ADDR:  exp_data <= {4'h0, exp_ioread};
					default:                      exp_data <= 8'h00;
				endcase
			end
			if (reg_write_i) begin
				case (reg_address_i)
					cw_trig_io_pkg::TRIGSRC_ADDR: sh_src <= reg_datai_i;
					cw_trig_io_pkg::TRIGMOD_ADDR: sh_mod <= reg_datai_i;
					cw_trig_io_pkg::IOROUTE_ADDR: sh_route[8 * reg_bytecnt_i[2:0] +: 8] <= reg_datai_i;
					default: ;
				endcase
			end
		end
	end

	// mid cycle compare, inputs settled since 1 ns after the edge
	always @(negedge clk) begin : compare
		logic [1:0] trig_exp;
		logic [1:0] rx_exp;
		if (!reset) begin
			trig_exp = ref_trigger(sh_src, sh_mod, lines_i, adv_i);
			rx_exp = ref_receive(sh_route[31:0], pins_i);
			check_val("trigger_ext_o", trig_exp[1], trigger_ext_o);
			check_val("trigger_o", trig_exp[0], trigger_o);
			check_val("fpa_drive_o", {trig_exp[0], sh_mod[3]}, fpa_drive_o);
			check_val("pins_o", ref_drives(sh_route[31:0], exp_power_off, uart_tx_i, usi_out_i),
				pins_o);
			check_val("uart_rx_o", rx_exp[1], uart_rx_o);
			check_val("usi_in_o", rx_exp[0], usi_in_o);
			check_val("targetpower_off_o", exp_power_off, targetpower_off_o);
			check_val("avrprog_en_o", sh_route[40], avrprog_en_o);
			check_val("gpio_o", sh_route[55:48], gpio_o);
			check_val("reg_datao_o", exp_valid ? exp_data : 8'h00, reg_datao_o);
			check_val("reg_hyplen_o", ref_len(reg_hypaddress_i), reg_hyplen_o);
		end
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("timeout: run did not finish within %0d cycles, errors: %0d",
			2 * TEST_CYCLES, errors);
		$display("TEST FAILED");
		$finish;
	end

	initial begin
		logic [31:0] r;
		logic [7:0]  data;
		logic [5:0]  addr;
		reset = 1'b1;
		reg_write_i = 1'b0;
		reg_read_i = 1'b0;
		reg_addrvalid_i = 1'b0;
		reg_address_i = '0;
		reg_hypaddress_i = '0;
		reg_bytecnt_i = '0;
		reg_datai_i = '0;
		lines_i = '0;
		adv_i = '0;
		pins_i = '0;
		uart_tx_i = 1'b1;
		usi_out_i = 1'b1;
		repeat (2) @(posedge clk);
		#1;
		reset = 1'b0;
		drive_io();

		// reset values, unknown addresses and the length table
		host_read(cw_trig_io_pkg::TRIGSRC_ADDR, 3'd0);
		host_read(cw_trig_io_pkg::TRIGMOD_ADDR, 3'd0);
		host_read(cw_trig_io_pkg::IOROUTE_ADDR, 3'd0);
		host_read(cw_trig_io_pkg::IOROUTE_ADDR, 3'd1);
		host_read(6'd0, 3'd0);
		host_read(6'd63, 3'd0);
		for (int a = 0; a < 64; a++) begin
			next_cycle();
			reg_hypaddress_i = a[5:0];
		end

		// write then read back every byte target
		for (int n = 0; n < N_ROUNDS; n++) begin
			for (int t = 0; t < 10; t++) begin
				r = next_rand();
				addr = (t == 0) ? cw_trig_io_pkg::TRIGSRC_ADDR :
					(t == 1) ? cw_trig_io_pkg::TRIGMOD_ADDR : cw_trig_io_pkg::IOROUTE_ADDR;
				host_write(addr, (t < 2) ? 3'd0 : 3'(t - 2), r[31:24]);
				host_read(addr, (t < 2) ? 3'd0 : 3'(t - 2));
			end
		end
		host_write(cw_trig_io_pkg::IOROUTE_ADDR, 3'd5, 8'h00); // target power back on

		// trigger combine and module select, incl. off mode and codes 4..7
		for (int n = 0; n < N_TRIG; n++) begin
			r = next_rand();
			host_write(cw_trig_io_pkg::TRIGSRC_ADDR, 3'd0, r[31:24]);
			r = next_rand();
			host_write(cw_trig_io_pkg::TRIGMOD_ADDR, 3'd0, r[31:24]);
		end

		// pin routing with power on
		for (int n = 0; n < N_PIN; n++) begin
			r = next_rand();
			data = r[31:24];
			if (r[23:22] == 2'd0) begin
				data = data & 8'hF0; // no tx, rx, usi select: oc and idle cases
			end
			host_write(cw_trig_io_pkg::IOROUTE_ADDR, {1'b0, r[21:20]}, data);
		end

		// power off blanks every pin, ioread keeps sampling
		for (int p = 0; p < 4; p++) begin
			host_write(cw_trig_io_pkg::IOROUTE_ADDR, 3'(p), 8'hC0); // gpio high
		end
		host_write(cw_trig_io_pkg::IOROUTE_ADDR, 3'd5, 8'h02);
		next_cycle(); // write edge
		next_cycle(); // power-off register edge
		check_val("targetpower_off_o", 1'b1, targetpower_off_o);
		check_val("pins_o oe", 4'h0, {pins_o[6], pins_o[4], pins_o[2], pins_o[0]});
		for (int n = 0; n < N_OFF; n++) begin
			next_cycle();
			host_read(cw_trig_io_pkg::IOREAD_ADDR, 3'd0);
		end

		next_cycle();
		next_cycle();
		@(posedge clk);
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- cw_trig_io.f
rtl/cw_trig_io_pkg.sv
rtl/cw_reg_bank.sv
rtl/cw_trigger_mux.sv
rtl/cw_target_io_router.sv
rtl/cw_reg_readback.sv
rtl/cw_trig_io_top.sv
tb/cw_trig_io_tb.sv
